// File: source/fe_pkg.sv
package fe_pkg;

    ////////////////////////////////////////////////////////////
    // instruction side widths
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_t;
    // branch class, sits on top of the predicted pc
    typedef logic [1:0]  brtype_t;
    typedef logic [33:0] pred_t;
    // bit 1 is slot 1, the older one; only 00, 10, 11 are legal
    typedef logic [1:0]  slot_valid_t;

    localparam brtype_t BR_NONE     = 2'd0;
    localparam brtype_t BR_COND     = 2'd1;
    localparam brtype_t BR_DIRECT   = 2'd2;
    localparam brtype_t BR_INDIRECT = 2'd3;

    localparam pc_t RESET_PC = 32'h1c00_0000;

    // major opcode, ir[31:26]
    localparam logic [5:0] OP_JIRL = 6'h13;
    localparam logic [5:0] OP_B    = 6'h14;
    localparam logic [5:0] OP_BL   = 6'h15;
    // beq, bne, blt, bge, bltu, bgeu are contiguous
    localparam logic [5:0] OP_BEQ  = 6'h16;
    localparam logic [5:0] OP_BGEU = 6'h1b;

    // rom word address, taken from pc[9:2]
    localparam int ROM_AW = 8;

endpackage

// File: source/ibuf_pkg.sv
package ibuf_pkg;

    ////////////////////////////////////////////////////////////
    // instruction buffer geometry
    ////////////////////////////////////////////////////////////

    // entries in the circular queue, power of two
    localparam int IBUF_DEPTH = 16;
    localparam int IBUF_IW    = $clog2(IBUF_DEPTH);

    // slot index wraps on its own width
    typedef logic [IBUF_IW-1:0] ibuf_idx_t;

    // one extra bit so a full depth of credits fits
    typedef logic [IBUF_IW:0]   credit_t;

endpackage

// File: source/inst_rom.sv
`timescale 1ns/1ps

module inst_rom (
    input  logic                      clk,
    // load port, used while the core sits in reset
    input  logic                      i_we,
    input  logic [fe_pkg::ROM_AW-1:0] i_waddr,
    input  fe_pkg::inst_t             i_wdata,
    // fetch read ports
    input  logic [fe_pkg::ROM_AW-1:0] i_raddr1,
    input  logic [fe_pkg::ROM_AW-1:0] i_raddr2,
    output fe_pkg::inst_t             o_rdata1,
    output fe_pkg::inst_t             o_rdata2
);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    fe_pkg::inst_t mem [2**fe_pkg::ROM_AW];

    // one write per edge from the load port
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // reads
    ////////////////////////////////////////////////////////////

    // asynchronous, both words visible in the fetch cycle
    assign o_rdata1 = mem[i_raddr1];
    assign o_rdata2 = mem[i_raddr2];

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                      clk,
    input  logic                      rstn,
    // redirect from the back end
    input  logic                      i_flush,
    input  fe_pkg::pc_t               i_flush_pc,
    // slots freed by the buffer
    input  ibuf_pkg::credit_t         i_credit_ret,
    // rom side
    output logic [fe_pkg::ROM_AW-1:0] o_raddr1,
    output logic [fe_pkg::ROM_AW-1:0] o_raddr2,
    input  fe_pkg::inst_t             i_rdata1,
    input  fe_pkg::inst_t             i_rdata2,
    // pair to the buffer
    output fe_pkg::pc_t               o_pc1,
    output fe_pkg::inst_t             o_ir1,
    output fe_pkg::pred_t             o_pred1,
    output fe_pkg::pc_t               o_pc2,
    output fe_pkg::inst_t             o_ir2,
    output fe_pkg::pred_t             o_pred2,
    output fe_pkg::slot_valid_t       o_valid
);

    // boot holds the pair back for the first cycle out of reset
    typedef enum logic {
        FETCH_BOOT,
        FETCH_RUN
    } fetch_state_t;

    fetch_state_t      state;
    fe_pkg::pc_t       pc;
    fe_pkg::pc_t       pc_seq;
    fe_pkg::pc_t       next_pc;
    ibuf_pkg::credit_t credits;
    ibuf_pkg::credit_t sent;

    ////////////////////////////////////////////////////////////
    // predecode
    ////////////////////////////////////////////////////////////

    // branch class on top, predicted next pc below
    function automatic fe_pkg::pred_t predecode(input fe_pkg::pc_t pc_in,
                                                input fe_pkg::inst_t ir);
        logic [5:0]      opcode;
        logic [25:0]     offs;
        fe_pkg::brtype_t br;
        fe_pkg::pc_t     target;
        opcode = ir[31:26];
        // offs26 is split, high part in ir[9:0]
        offs   = {ir[9:0], ir[25:10]};
        if (opcode == fe_pkg::OP_B || opcode == fe_pkg::OP_BL) begin
            br = fe_pkg::BR_DIRECT;
        end else if (opcode == fe_pkg::OP_JIRL) begin
            br = fe_pkg::BR_INDIRECT;
        end else if (opcode >= fe_pkg::OP_BEQ && opcode <= fe_pkg::OP_BGEU) begin
            br = fe_pkg::BR_COND;
        end else begin
            br = fe_pkg::BR_NONE;
        end
        // only direct jumps are followed
        if (br == fe_pkg::BR_DIRECT) begin
            target = pc_in + {{4{offs[25]}}, offs, 2'b00};
        end else begin
            target = pc_in + 32'd4;
        end
        return {br, target};
    endfunction

    assign pc_seq   = pc + 32'd4;
    assign o_raddr1 = pc[fe_pkg::ROM_AW+1:2];
    assign o_raddr2 = pc_seq[fe_pkg::ROM_AW+1:2];

    assign o_pc1   = pc;
    assign o_ir1   = i_rdata1;
    assign o_pred1 = predecode(pc, i_rdata1);
    assign o_pc2   = pc_seq;
    assign o_ir2   = i_rdata2;
    assign o_pred2 = predecode(pc_seq, i_rdata2);

    ////////////////////////////////////////////////////////////
    // send decision
    ////////////////////////////////////////////////////////////

    always_comb begin
        o_valid = 2'b00;
        // nothing goes out on a flush edge
        if (state == FETCH_RUN && !i_flush && credits >= ibuf_pkg::credit_t'(1)) begin
            o_valid[1] = 1'b1;
            // pair ends at a taken jump
            if (credits >= ibuf_pkg::credit_t'(2) && o_pred1[33:32] != fe_pkg::BR_DIRECT) begin
                o_valid[0] = 1'b1;
            end
        end
    end

    assign sent = ibuf_pkg::credit_t'(o_valid[1]) + ibuf_pkg::credit_t'(o_valid[0]);

    // follow the last slot that went out
    always_comb begin
        case (o_valid)
            2'b11:   next_pc = o_pred2[31:0];
            2'b10:   next_pc = o_pred1[31:0];
            default: next_pc = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= FETCH_BOOT;
            pc      <= fe_pkg::RESET_PC;
            credits <= ibuf_pkg::credit_t'(ibuf_pkg::IBUF_DEPTH);
        end else begin
            state   <= FETCH_RUN;
            // returned credits count even on a flush edge
            credits <= credits + i_credit_ret - sent;
            pc      <= i_flush ? i_flush_pc : next_pc;
        end
    end

endmodule

// File: source/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer (
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_flush,
    input  logic                i_stall,
    // pair from fetch, slot 1 is older
    input  fe_pkg::pc_t         i_pc1,
    input  fe_pkg::inst_t       i_ir1,
    input  fe_pkg::pred_t       i_pred1,
    input  fe_pkg::pc_t         i_pc2,
    input  fe_pkg::inst_t       i_ir2,
    input  fe_pkg::pred_t       i_pred2,
    input  fe_pkg::slot_valid_t i_valid,
    // registered pair to decode
    output fe_pkg::pc_t         o_dec_pc1,
    output fe_pkg::inst_t       o_dec_ir1,
    output fe_pkg::pred_t       o_dec_pred1,
    output fe_pkg::pc_t         o_dec_pc2,
    output fe_pkg::inst_t       o_dec_ir2,
    output fe_pkg::pred_t       o_dec_pred2,
    output fe_pkg::slot_valid_t o_dec_valid,
    // freed slots back to fetch
    output ibuf_pkg::credit_t   o_credit_ret
);

    ////////////////////////////////////////////////////////////
    // queue storage
    ////////////////////////////////////////////////////////////

    fe_pkg::pc_t   pc_q   [ibuf_pkg::IBUF_DEPTH];
    fe_pkg::inst_t ir_q   [ibuf_pkg::IBUF_DEPTH];
    fe_pkg::pred_t pred_q [ibuf_pkg::IBUF_DEPTH];

    // head is the oldest entry, tail the next free one
    ibuf_pkg::ibuf_idx_t head;
    ibuf_pkg::ibuf_idx_t head_p1;
    ibuf_pkg::ibuf_idx_t tail;
    ibuf_pkg::ibuf_idx_t tail_p1;

    // stored entries only
    ibuf_pkg::credit_t count;
    // incoming this edge
    ibuf_pkg::credit_t n_in;
    // stored plus incoming
    ibuf_pkg::credit_t total;
    // moved to the decode registers this edge
    ibuf_pkg::credit_t n_deq;

    // oldest two of stored then incoming
    fe_pkg::pc_t   pick_pc1;
    fe_pkg::inst_t pick_ir1;
    fe_pkg::pred_t pick_pred1;
    fe_pkg::pc_t   pick_pc2;
    fe_pkg::inst_t pick_ir2;
    fe_pkg::pred_t pick_pred2;

    // indices wrap on their own width
    assign head_p1 = head + ibuf_pkg::ibuf_idx_t'(1);
    assign tail_p1 = tail + ibuf_pkg::ibuf_idx_t'(1);

    assign n_in  = ibuf_pkg::credit_t'(i_valid[1]) + ibuf_pkg::credit_t'(i_valid[0]);
    assign total = count + n_in;

    // up to two leave when decode is free
    always_comb begin
        if (i_stall) begin
            n_deq = '0;
        end else if (total >= ibuf_pkg::credit_t'(2)) begin
            n_deq = ibuf_pkg::credit_t'(2);
        end else begin
            n_deq = total;
        end
    end

    ////////////////////////////////////////////////////////////
    // output select with bypass
    ////////////////////////////////////////////////////////////

    always_comb begin
        // first slot: queue head, else straight from fetch
        if (count != '0) begin
            pick_pc1   = pc_q[head];
            pick_ir1   = ir_q[head];
            pick_pred1 = pred_q[head];
        end else begin
            pick_pc1   = i_pc1;
            pick_ir1   = i_ir1;
            pick_pred1 = i_pred1;
        end
        // second slot depends on how much is stored
        if (count >= ibuf_pkg::credit_t'(2)) begin
            pick_pc2   = pc_q[head_p1];
            pick_ir2   = ir_q[head_p1];
            pick_pred2 = pred_q[head_p1];
        end else if (count == ibuf_pkg::credit_t'(1)) begin
            pick_pc2   = i_pc1;
            pick_ir2   = i_ir1;
            pick_pred2 = i_pred1;
        end else begin
            pick_pc2   = i_pc2;
            pick_ir2   = i_ir2;
            pick_pred2 = i_pred2;
        end
    end

    // incoming always written at tail, bypassed ones get popped at once
    always_ff @(posedge clk) begin
        if (i_valid[1]) begin
            pc_q[tail]   <= i_pc1;
            ir_q[tail]   <= i_ir1;
            pred_q[tail] <= i_pred1;
        end
        if (i_valid[0]) begin
            pc_q[tail_p1]   <= i_pc2;
            ir_q[tail_p1]   <= i_ir2;
            pred_q[tail_p1] <= i_pred2;
        end
    end

    // decode payload, held while stalled
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_dec_pc1   <= pick_pc1;
            o_dec_ir1   <= pick_ir1;
            o_dec_pred1 <= pick_pred1;
            o_dec_pc2   <= pick_pc2;
            o_dec_ir2   <= pick_ir2;
            o_dec_pred2 <= pick_pred2;
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers, valid, credit return
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            o_dec_valid  <= 2'b00;
            o_credit_ret <= '0;
        end else if (i_flush) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            o_dec_valid  <= 2'b00;
            // everything held goes back, plus whatever arrived
            o_credit_ret <= total;
        end else begin
            head         <= head + ibuf_pkg::ibuf_idx_t'(n_deq);
            tail         <= tail + ibuf_pkg::ibuf_idx_t'(n_in);
            count        <= total - n_deq;
            o_credit_ret <= n_deq;
            if (!i_stall) begin
                // oldest first, so 01 never shows up
                if (total >= ibuf_pkg::credit_t'(2)) begin
                    o_dec_valid <= 2'b11;
                end else if (total == ibuf_pkg::credit_t'(1)) begin
                    o_dec_valid <= 2'b10;
                end else begin
                    o_dec_valid <= 2'b00;
                end
            end
        end
    end

endmodule

// File: source/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
    input  logic                      clk,
    input  logic                      rstn,
    // rom load, only while in reset
    input  logic                      i_load_en,
    input  logic [fe_pkg::ROM_AW-1:0] i_load_addr,
    input  fe_pkg::inst_t             i_load_data,
    // back end control
    input  logic                      i_flush,
    input  fe_pkg::pc_t               i_flush_pc,
    input  logic                      i_stall,
    // decode side
    output fe_pkg::pc_t               o_dec_pc1,
    output fe_pkg::inst_t             o_dec_ir1,
    output fe_pkg::pred_t             o_dec_pred1,
    output fe_pkg::pc_t               o_dec_pc2,
    output fe_pkg::inst_t             o_dec_ir2,
    output fe_pkg::pred_t             o_dec_pred2,
    output fe_pkg::slot_valid_t       o_dec_valid
);

    ////////////////////////////////////////////////////////////
    // internal wiring
    ////////////////////////////////////////////////////////////

    logic [fe_pkg::ROM_AW-1:0] rom_raddr1;
    logic [fe_pkg::ROM_AW-1:0] rom_raddr2;
    fe_pkg::inst_t             rom_rdata1;
    fe_pkg::inst_t             rom_rdata2;

    // fetch to buffer pair
    fe_pkg::pc_t               f_pc1;
    fe_pkg::inst_t             f_ir1;
    fe_pkg::pred_t             f_pred1;
    fe_pkg::pc_t               f_pc2;
    fe_pkg::inst_t             f_ir2;
    fe_pkg::pred_t             f_pred2;
    fe_pkg::slot_valid_t       f_valid;
    ibuf_pkg::credit_t         credit_ret;

    inst_rom u_rom (
        .clk      (clk),
        .i_we     (i_load_en),
        .i_waddr  (i_load_addr),
        .i_wdata  (i_load_data),
        .i_raddr1 (rom_raddr1),
        .i_raddr2 (rom_raddr2),
        .o_rdata1 (rom_rdata1),
        .o_rdata2 (rom_rdata2)
    );

    fetch_unit u_fetch (
        .clk          (clk),
        .rstn         (rstn),
        .i_flush      (i_flush),
        .i_flush_pc   (i_flush_pc),
        .i_credit_ret (credit_ret),
        .o_raddr1     (rom_raddr1),
        .o_raddr2     (rom_raddr2),
        .i_rdata1     (rom_rdata1),
        .i_rdata2     (rom_rdata2),
        .o_pc1        (f_pc1),
        .o_ir1        (f_ir1),
        .o_pred1      (f_pred1),
        .o_pc2        (f_pc2),
        .o_ir2        (f_ir2),
        .o_pred2      (f_pred2),
        .o_valid      (f_valid)
    );

    inst_buffer u_ibuf (
        .clk          (clk),
        .rstn         (rstn),
        .i_flush      (i_flush),
        .i_stall      (i_stall),
        .i_pc1        (f_pc1),
        .i_ir1        (f_ir1),
        .i_pred1      (f_pred1),
        .i_pc2        (f_pc2),
        .i_ir2        (f_ir2),
        .i_pred2      (f_pred2),
        .i_valid      (f_valid),
        .o_dec_pc1    (o_dec_pc1),
        .o_dec_ir1    (o_dec_ir1),
        .o_dec_pred1  (o_dec_pred1),
        .o_dec_pc2    (o_dec_pc2),
        .o_dec_ir2    (o_dec_ir2),
        .o_dec_pred2  (o_dec_pred2),
        .o_dec_valid  (o_dec_valid),
        .o_credit_ret (credit_ret)
    );

endmodule

// File: bench/frontend_checker.sv
`timescale 1ns/1ps

module frontend_checker (
    input logic                clk,
    input logic                rstn,
    input logic                i_flush,
    input logic                i_stall,
    input fe_pkg::pc_t         i_dec_pc1,
    input fe_pkg::inst_t       i_dec_ir1,
    input fe_pkg::pred_t       i_dec_pred1,
    input fe_pkg::pc_t         i_dec_pc2,
    input fe_pkg::inst_t       i_dec_ir2,
    input fe_pkg::pred_t       i_dec_pred2,
    input fe_pkg::slot_valid_t i_dec_valid,
    input ibuf_pkg::credit_t   i_credit_ret
);

    ////////////////////////////////////////////////////////////
    // decode side protocol
    ////////////////////////////////////////////////////////////

    // oldest first, slot 2 alone is illegal
    assert property (@(posedge clk) disable iff (!rstn) i_dec_valid != 2'b01)
        else $error("decode valid showed 01");

    // never more back than the queue holds
    assert property (@(posedge clk) disable iff (!rstn)
        i_credit_ret <= ibuf_pkg::credit_t'(ibuf_pkg::IBUF_DEPTH))
        else $error("credit return above buffer depth");

    // a held pair keeps valid and payload
    assert property (@(posedge clk) disable iff (!rstn)
        (i_stall && !i_flush && i_dec_valid != 2'b00) |=>
        $stable({i_dec_valid, i_dec_pc1, i_dec_ir1, i_dec_pred1,
                 i_dec_pc2, i_dec_ir2, i_dec_pred2}))
        else $error("decode outputs moved while stalled");

    assert property (@(posedge clk) disable iff (!rstn) i_flush |=> i_dec_valid == 2'b00)
        else $error("decode valid still set after flush");

endmodule

bind inst_buffer frontend_checker u_checker (
    .clk          (clk),
    .rstn         (rstn),
    .i_flush      (i_flush),
    .i_stall      (i_stall),
    .i_dec_pc1    (o_dec_pc1),
    .i_dec_ir1    (o_dec_ir1),
    .i_dec_pred1  (o_dec_pred1),
    .i_dec_pc2    (o_dec_pc2),
    .i_dec_ir2    (o_dec_ir2),
    .i_dec_pred2  (o_dec_pred2),
    .i_dec_valid  (o_dec_valid),
    .i_credit_ret (o_credit_ret)
);

// File: bench/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;

    ////////////////////////////////////////////////////////////
    // run geometry
    ////////////////////////////////////////////////////////////

    localparam int CLK_PERIOD       = 20;
    localparam int RESET_CYCLES     = 5;
    localparam int ROM_WORDS        = 2**fe_pkg::ROM_AW;
    localparam int N_INSTR          = 3000;
    localparam int CYCLES_PER_INSTR = 20;
    localparam int WATCHDOG_NS      =
        (ROM_WORDS + RESET_CYCLES + CYCLES_PER_INSTR * N_INSTR) * CLK_PERIOD;
    localparam logic [31:0] SEED    = 32'h6657_162f;

    logic                      clk;
    logic                      rstn;
    logic                      load_en;
    logic [fe_pkg::ROM_AW-1:0] load_addr;
    fe_pkg::inst_t             load_data;
    logic                      flush;
    fe_pkg::pc_t               flush_pc;
    logic                      stall;

    fe_pkg::pc_t               dec_pc1;
    fe_pkg::inst_t             dec_ir1;
    fe_pkg::pred_t             dec_pred1;
    fe_pkg::pc_t               dec_pc2;
    fe_pkg::inst_t             dec_ir2;
    fe_pkg::pred_t             dec_pred2;
    fe_pkg::slot_valid_t       dec_valid;

    // lfsr state and the model's view of the program
    logic [31:0]   lfsr;
    fe_pkg::inst_t rom_model [ROM_WORDS];
    fe_pkg::pc_t   model_pc;
    int            consumed;
    int            cycle;

    frontend_top i_dut (
        .clk         (clk),
        .rstn        (rstn),
        .i_load_en   (load_en),
        .i_load_addr (load_addr),
        .i_load_data (load_data),
        .i_flush     (flush),
        .i_flush_pc  (flush_pc),
        .i_stall     (stall),
        .o_dec_pc1   (dec_pc1),
        .o_dec_ir1   (dec_ir1),
        .o_dec_pred1 (dec_pred1),
        .o_dec_pc2   (dec_pc2),
        .o_dec_ir2   (dec_ir2),
        .o_dec_pred2 (dec_pred2),
        .o_dec_valid (dec_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hang guard sized from the instruction budget
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired: only %0d of %0d instructions reached decode",
                 consumed, N_INSTR);
        $display("Simulation finished: FAIL");
        $fatal(1, "front end hung");
    end

    ////////////////////////////////////////////////////////////
    // random source
    ////////////////////////////////////////////////////////////

    // right shifting galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic fe_pkg::inst_t make_word();
        fe_pkg::inst_t w;
        w = take_bits(32);
        // about a quarter turn into b or bl
        if (take_bits(2) == 32'd0) begin
            w[31:26] = (take_bits(1) == 32'd1) ? fe_pkg::OP_BL : fe_pkg::OP_B;
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // branch class on top of the predicted next pc
    function automatic fe_pkg::pred_t expected_pred(input fe_pkg::pc_t pc,
                                                    input fe_pkg::inst_t ir);
        fe_pkg::brtype_t br;
        logic [31:0]     offs;
        fe_pkg::pc_t     target;
        if (ir[31:26] == fe_pkg::OP_B || ir[31:26] == fe_pkg::OP_BL) begin
            br = fe_pkg::BR_DIRECT;
        end else if (ir[31:26] == fe_pkg::OP_JIRL) begin
            br = fe_pkg::BR_INDIRECT;
        end else if (ir[31:26] >= fe_pkg::OP_BEQ && ir[31:26] <= fe_pkg::OP_BGEU) begin
            br = fe_pkg::BR_COND;
        end else begin
            br = fe_pkg::BR_NONE;
        end
        // offs26 high part lives in ir[9:0]
        offs   = {{6{ir[9]}}, ir[9:0], ir[25:10]};
        target = (br == fe_pkg::BR_DIRECT) ? pc + (offs << 2) : pc + 32'd4;
        return {br, target};
    endfunction

    task automatic compare(input logic [63:0] got, input logic [63:0] exp,
                           input string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // one consumed slot against the walk and then a step of the walk
    task automatic check_slot(input int slot, input fe_pkg::pc_t pc,
                              input fe_pkg::inst_t ir, input fe_pkg::pred_t pred);
        fe_pkg::inst_t exp_ir;
        fe_pkg::pred_t exp_pred;
        exp_ir   = rom_model[model_pc[fe_pkg::ROM_AW+1:2]];
        exp_pred = expected_pred(model_pc, exp_ir);
        compare(64'(pc), 64'(model_pc), $sformatf("slot %0d pc", slot));
        compare(64'(ir), 64'(exp_ir), $sformatf("slot %0d instruction", slot));
        compare(64'(pred), 64'(exp_pred), $sformatf("slot %0d prediction", slot));
        model_pc = exp_pred[31:0];
        consumed++;
    endtask

    // called between edges to look at what the next edge does
    task automatic score_edge();
        if (cycle < 2) begin
            compare(64'(dec_valid), 64'd0, "o_dec_valid right after reset");
        end
        if (!stall && dec_valid != 2'b00) begin
            compare(64'(dec_valid == 2'b01), 64'd0, "o_dec_valid slot order");
            if (dec_valid[1]) begin
                check_slot(1, dec_pc1, dec_ir1, dec_pred1);
            end
            if (dec_valid[0]) begin
                check_slot(2, dec_pc2, dec_ir2, dec_pred2);
            end
        end
        // redirect comes after anything taken at the same edge
        if (flush) begin
            model_pc = flush_pc;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic drive_controls();
        int          phase;
        logic [31:0] r;
        phase = cycle % 400;
        flush = 1'b0;
        if (phase >= 200 && phase < 260) begin
            // long stall so the buffer fills and fetch runs dry
            stall = 1'b1;
            // odd windows flush twice while full
            if ((cycle / 400) % 2 == 1 && (phase == 230 || phase == 250)) begin
                r        = take_bits(30);
                flush    = 1'b1;
                flush_pc = {r[29:0], 2'b00};
            end
        end else begin
            stall = (take_bits(10) < 32'd307);
            if (take_bits(8) < 32'd5) begin
                r        = take_bits(30);
                flush    = 1'b1;
                flush_pc = {r[29:0], 2'b00};
            end
        end
    endtask

    initial begin
        lfsr       = SEED;
        rstn       = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        flush      = 1'b0;
        flush_pc   = '0;
        stall      = 1'b0;
        model_pc   = fe_pkg::RESET_PC;
        consumed   = 0;
        cycle      = 0;
        // rom image through the load port while the core is held in reset
        for (int a = 0; a < ROM_WORDS; a++) begin
            @(posedge clk);
            #1;
            rom_model[a] = make_word();
            load_en      = 1'b1;
            load_addr    = a[fe_pkg::ROM_AW-1:0];
            load_data    = rom_model[a];
            @(negedge clk);
            compare(64'(dec_valid), 64'd0, "o_dec_valid during reset");
        end
        for (int r = 0; r < RESET_CYCLES; r++) begin
            @(posedge clk);
            #1;
            load_en = 1'b0;
            @(negedge clk);
            compare(64'(dec_valid), 64'd0, "o_dec_valid during reset");
        end
        @(posedge clk);
        #1;
        rstn = 1'b1;
        drive_controls();
        while (consumed < N_INSTR) begin
            @(negedge clk);
            score_edge();
            @(posedge clk);
            #1;
            cycle++;
            drive_controls();
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: build.f
source/fe_pkg.sv
source/ibuf_pkg.sv
source/inst_rom.sv
source/fetch_unit.sv
source/inst_buffer.sv
source/frontend_top.sv
bench/frontend_checker.sv
bench/tb_frontend.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir
TOP      = tb_frontend
FILELIST = build.f
LOG      = sim.log
PASS_MSG = Simulation finished: PASS

.PHONY: sim clean

# build, run, then decide on the log contents
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
